/* tb.f */
source/rv_decode_pkg.sv
source/branch_compare.sv
source/reg_file.sv
source/csr_file.sv
source/inst_decode.sv
source/decode_stage.sv
sim/decode_stage_tb.sv

/* sim/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int N_RAND      = 165;                 // 15 words per opcode class.
    localparam int N_BRANCH    = 8 * 5 * 5;           // every funct3 on 5x5 operands.
    localparam int NUM_WORDS   = N_RAND + N_BRANCH;
    localparam int MAX_CYCLES  = NUM_WORDS * 4 + 100; // issue, two gaps, one write.
    localparam int WATCHDOG_NS = MAX_CYCLES * CLK_PERIOD;

    logic                        clk_i;
    logic                        rst_i;
    logic                        ifu_valid_i;
    rv_decode_pkg::fetch_bus_t   ifu_bus_i;
    logic                        rf_we_i;
    logic [4:0]                  rf_waddr_i;
    logic [31:0]                 rf_wdata_i;
    logic                        csr_we_i;
    logic [11:0]                 csr_waddr_i;
    logic [31:0]                 csr_wdata_i;
    rv_decode_pkg::decode_bus_t  decode_bus_o;
    logic                        valid_o;

    logic [31:0]                 rf_model [32];
    logic [31:0]                 csr_model [4];       // mstatus, mtvec, mepc, mcause.
    rv_decode_pkg::decode_bus_t  exp_q [$];
    int                          strobe_count;
    int                          pulse_count;

    decode_stage #(
        .NUM_REGS (32)
    ) u_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ifu_valid_i  (ifu_valid_i),
        .ifu_bus_i    (ifu_bus_i),
        .rf_we_i      (rf_we_i),
        .rf_waddr_i   (rf_waddr_i),
        .rf_wdata_i   (rf_wdata_i),
        .csr_we_i     (csr_we_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_wdata_i  (csr_wdata_i),
        .decode_bus_o (decode_bus_o),
        .valid_o      (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] csr_model_read(input logic [11:0] addr);
        case (addr)
            rv_decode_pkg::CSR_MSTATUS: return csr_model[0];
            rv_decode_pkg::CSR_MTVEC:   return csr_model[1];
            rv_decode_pkg::CSR_MEPC:    return csr_model[2];
            rv_decode_pkg::CSR_MCAUSE:  return csr_model[3];
            default:                    return 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;             // reserved encodings never branch.
        endcase
    endfunction

    function automatic rv_decode_pkg::decode_bus_t ref_decode(
        input rv_decode_pkg::fetch_bus_t f
    );
        rv_decode_pkg::decode_bus_t d;
        logic [31:0]                w;
        w          = f.inst;
        d          = '0;
        d.pc       = f.pc;
        d.opcode   = w[6:0];
        d.rd       = w[11:7];
        d.funct3   = w[14:12];
        d.funct7   = w[31:25];
        d.rs1_val  = rf_model[w[19:15]];
        d.rs2_val  = rf_model[w[24:20]];
        d.csr_addr = w[31:20];
        d.csr_val  = csr_model_read(w[31:20]);
        case (w[6:0])
            rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC: begin
                d.optype = rv_decode_pkg::OPT_U;
                d.imm    = {w[31:12], 12'd0};
            end
            rv_decode_pkg::OP_JAL: begin
                d.optype = rv_decode_pkg::OPT_J;
                d.imm    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            rv_decode_pkg::OP_JALR, rv_decode_pkg::OP_LOAD, rv_decode_pkg::OP_IMM: begin
                d.optype = rv_decode_pkg::OPT_I;
                d.imm    = {{20{w[31]}}, w[31:20]};
            end
            rv_decode_pkg::OP_STORE: begin
                d.optype = rv_decode_pkg::OPT_S;
                d.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            rv_decode_pkg::OP_BRANCH: begin
                d.optype   = rv_decode_pkg::OPT_B;
                d.imm      = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                d.br_taken = branch_taken(w[14:12], d.rs1_val, d.rs2_val);
            end
            rv_decode_pkg::OP_REG:    d.optype = rv_decode_pkg::OPT_R;
            rv_decode_pkg::OP_SYSTEM: d.optype = rv_decode_pkg::OPT_PRIV;
            default:                  d.optype = rv_decode_pkg::OPT_NONE;
        endcase
        return d;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic match_word_fields(input rv_decode_pkg::decode_bus_t got,
                                     input rv_decode_pkg::decode_bus_t exp);
        check_value(got.pc,       exp.pc,       "pc");
        check_value(got.opcode,   exp.opcode,   "opcode");
        check_value(got.optype,   exp.optype,   "optype");
        check_value(got.imm,      exp.imm,      "imm");
        check_value(got.rd,       exp.rd,       "rd");
        check_value(got.funct3,   exp.funct3,   "funct3");
        check_value(got.funct7,   exp.funct7,   "funct7");
        check_value(got.csr_addr, exp.csr_addr, "csr_addr");
    endtask

    task automatic compare_bus(input rv_decode_pkg::decode_bus_t got,
                               input rv_decode_pkg::decode_bus_t exp);
        match_word_fields(got, exp);
        check_value(got.rs1_val,  exp.rs1_val,  "rs1_val");
        check_value(got.rs2_val,  exp.rs2_val,  "rs2_val");
        check_value(got.csr_val,  exp.csr_val,  "csr_val");
        check_value(got.br_taken, exp.br_taken, "br_taken");
    endtask

    initial begin : compare_proc
        rv_decode_pkg::decode_bus_t exp;
        rv_decode_pkg::decode_bus_t last_exp;
        logic                       strobe_prev;
        strobe_prev = 1'b0;
        last_exp    = '0;
        forever begin
            @(posedge clk_i);
            if (rst_i) begin
                strobe_prev = 1'b0;
                last_exp    = '0;             // reset clears the held word.
            end else begin
                check_value(valid_o, strobe_prev, "valid_o one cycle after strobe");
                if (valid_o === 1'b1) begin
                    pulse_count++;
                    exp = exp_q.pop_front();
                    compare_bus(decode_bus_o, exp);
                    last_exp = exp;
                end else begin
                    match_word_fields(decode_bus_o, last_exp);  // held between strobes.
                end
                strobe_prev = ifu_valid_i;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Error at %0t ns: watchdog expired, the run did not finish", $time);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus, one cycle per task
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [11:0] csr_pick(input int sel);
        case (sel)
            0:       return rv_decode_pkg::CSR_MSTATUS;
            1:       return rv_decode_pkg::CSR_MTVEC;
            2:       return rv_decode_pkg::CSR_MEPC;
            3:       return rv_decode_pkg::CSR_MCAUSE;
            default: return 12'h7c0;          // not implemented.
        endcase
    endfunction

    function automatic logic known_opcode(input logic [6:0] op);
        case (op)
            rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC, rv_decode_pkg::OP_JAL,
            rv_decode_pkg::OP_JALR, rv_decode_pkg::OP_BRANCH, rv_decode_pkg::OP_LOAD,
            rv_decode_pkg::OP_STORE, rv_decode_pkg::OP_IMM, rv_decode_pkg::OP_REG,
            rv_decode_pkg::OP_SYSTEM: return 1'b1;
            default:                  return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] random_inst(input int sel);
        logic [31:0] w;
        logic [6:0]  op;
        w = $urandom;
        case (sel % 11)
            0:       op = rv_decode_pkg::OP_LUI;
            1:       op = rv_decode_pkg::OP_AUIPC;
            2:       op = rv_decode_pkg::OP_JAL;
            3:       op = rv_decode_pkg::OP_JALR;
            4:       op = rv_decode_pkg::OP_BRANCH;
            5:       op = rv_decode_pkg::OP_LOAD;
            6:       op = rv_decode_pkg::OP_STORE;
            7:       op = rv_decode_pkg::OP_IMM;
            8:       op = rv_decode_pkg::OP_REG;
            9:       op = rv_decode_pkg::OP_SYSTEM;
            default: begin
                op = 7'($urandom);
                while (known_opcode(op)) begin
                    op = 7'($urandom);
                end
            end
        endcase
        w[6:0] = op;
        if (op == rv_decode_pkg::OP_SYSTEM) begin
            w[31:20] = csr_pick($urandom_range(0, 4));
        end
        return w;
    endfunction

    task automatic idle_cycle();
        @(negedge clk_i);
        ifu_valid_i = 1'b0;
        ifu_bus_i   = {$urandom, $urandom}; // must not reach the held word.
        rf_we_i     = 1'b0;
        csr_we_i    = 1'b0;
    endtask

    task automatic issue_word(input logic [31:0] pc, input logic [31:0] inst);
        rv_decode_pkg::fetch_bus_t f;
        f.pc   = pc;
        f.inst = inst;
        @(negedge clk_i);
        ifu_valid_i = 1'b1;
        ifu_bus_i   = f;
        rf_we_i     = 1'b0;
        csr_we_i    = 1'b0;
        exp_q.push_back(ref_decode(f));
        strobe_count++;
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
        @(negedge clk_i);
        ifu_valid_i = 1'b0;
        csr_we_i    = 1'b0;
        rf_we_i     = 1'b1;
        rf_waddr_i  = idx;
        rf_wdata_i  = data;
        if (idx != 5'd0) begin
            rf_model[idx] = data;             // x0 stays zero.
        end
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk_i);
        ifu_valid_i = 1'b0;
        rf_we_i     = 1'b0;
        csr_we_i    = 1'b1;
        csr_waddr_i = addr;
        csr_wdata_i = data;
        case (addr)
            rv_decode_pkg::CSR_MSTATUS: csr_model[0] = data;
            rv_decode_pkg::CSR_MTVEC:   csr_model[1] = data;
            rv_decode_pkg::CSR_MEPC:    csr_model[2] = data;
            rv_decode_pkg::CSR_MCAUSE:  csr_model[3] = data;
            default: ;
        endcase
    endtask

    initial begin : stimulus
        logic [31:0] pc;
        logic [31:0] edge_vals [5];
        void'($urandom(69));
        edge_vals    = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
                         32'h8000_0000, 32'hffff_ffff};
        strobe_count = 0;
        pulse_count  = 0;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = 32'd0;
        end
        for (int i = 0; i < 4; i++) begin
            csr_model[i] = 32'd0;
        end
        rst_i       = 1'b1;
        ifu_valid_i = 1'b0;
        ifu_bus_i   = '0;
        rf_we_i     = 1'b0;
        rf_waddr_i  = 5'd0;
        rf_wdata_i  = 32'd0;
        csr_we_i    = 1'b0;
        csr_waddr_i = 12'd0;
        csr_wdata_i = 32'd0;
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;
        repeat (3) idle_cycle();          // valid_o has to stay low here.

        for (int i = 0; i < 32; i++) begin
            write_reg(i[4:0], $urandom);
        end
        for (int i = 0; i < 5; i++) begin
            write_csr(csr_pick(i), $urandom);
        end

        // random words with random gaps and writes in between.
        pc = 32'h0000_1000;
        for (int n = 0; n < N_RAND; n++) begin
            issue_word(pc, random_inst(n));
            pc = pc + 32'd4;
            repeat ($urandom_range(0, 2)) idle_cycle();
            case ($urandom_range(0, 3))
                0:       write_reg(5'($urandom), $urandom);
                1:       write_csr(csr_pick($urandom_range(0, 4)), $urandom);
                default: ;
            endcase
        end

        // branch operands at the equal, signed and unsigned edges.
        for (int i = 0; i < 5; i++) begin
            write_reg(5'(i + 1), edge_vals[i]);
        end
        for (int f = 0; f < 8; f++) begin
            for (int a = 1; a <= 5; a++) begin
                for (int b = 1; b <= 5; b++) begin
                    issue_word(pc, {7'($urandom), 5'(b), 5'(a), 3'(f), 5'($urandom),
                                    rv_decode_pkg::OP_BRANCH});
                    pc = pc + 32'd4;
                end
            end
        end

        repeat (3) idle_cycle();
        check_value(pulse_count, strobe_count, "valid_o pulse count");
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int NUM_REGS = 32               // 16 gives rv32e.
) (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire                          ifu_valid_i,
    input  wire rv_decode_pkg::fetch_bus_t ifu_bus_i,
    input  wire                          rf_we_i,
    input  wire [4:0]                    rf_waddr_i,
    input  wire [31:0]                   rf_wdata_i,
    input  wire                          csr_we_i,
    input  wire [11:0]                   csr_waddr_i,
    input  wire [31:0]                   csr_wdata_i,
    output rv_decode_pkg::decode_bus_t   decode_bus_o,
    output logic                         valid_o
);

    wire [4:0]  rs1_idx;
    wire [4:0]  rs2_idx;
    wire [31:0] rs1_val;
    wire [31:0] rs2_val;
    wire [11:0] csr_addr;
    wire [31:0] csr_val;

    inst_decode u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ifu_valid_i  (ifu_valid_i),
        .ifu_bus_i    (ifu_bus_i),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .rs1_val_i    (rs1_val),
        .rs2_val_i    (rs2_val),
        .csr_addr_o   (csr_addr),
        .csr_val_i    (csr_val),
        .decode_bus_o (decode_bus_o),
        .valid_o      (valid_o)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr1_i (rs1_idx),
        .raddr2_i (rs2_idx),
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val),
        .we_i     (rf_we_i),
        .waddr_i  (rf_waddr_i),
        .wdata_i  (rf_wdata_i)
    );

    csr_file u_csr_file (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .raddr_i (csr_addr),
        .rdata_o (csr_val),
        .we_i    (csr_we_i),
        .waddr_i (csr_waddr_i),
        .wdata_i (csr_wdata_i)
    );

endmodule

`default_nettype wire

/* source/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire                          ifu_valid_i,
    input  wire rv_decode_pkg::fetch_bus_t ifu_bus_i,
    output logic [4:0]                   rs1_idx_o,
    output logic [4:0]                   rs2_idx_o,
    input  wire [31:0]                   rs1_val_i,
    input  wire [31:0]                   rs2_val_i,
    output logic [11:0]                  csr_addr_o,
    input  wire [31:0]                   csr_val_i,
    output rv_decode_pkg::decode_bus_t   decode_bus_o,
    output logic                         valid_o
);

    rv_decode_pkg::fetch_bus_t held;
    logic                      valid_q;
    rv_decode_pkg::inst_fmt_u  inst;
    rv_decode_pkg::optype_e    optype;
    rv_decode_pkg::cmp_fn_e    cmp_fn;
    logic                      br_legal;
    logic                      cmp_result;
    logic [31:0]               imm_i;
    logic [31:0]               imm_s;
    logic [31:0]               imm_b;
    logic [31:0]               imm_u;
    logic [31:0]               imm_j;
    logic [31:0]               imm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            held    <= '0;
        end else begin
            valid_q <= ifu_valid_i;           // one-cycle pulse per strobe.
            if (ifu_valid_i) begin
                held <= ifu_bus_i;
            end
        end
    end

    assign inst    = held.inst;
    assign valid_o = valid_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // format decode and immediates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    assign imm_b = {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                    inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'd0};
    assign imm_j = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                    inst.j.imm_10_1, 1'b0};

    always_comb begin
        case (inst.r.opcode)
            rv_decode_pkg::OP_LUI,
            rv_decode_pkg::OP_AUIPC:  optype = rv_decode_pkg::OPT_U;
            rv_decode_pkg::OP_JAL:    optype = rv_decode_pkg::OPT_J;
            rv_decode_pkg::OP_JALR,
            rv_decode_pkg::OP_LOAD,
            rv_decode_pkg::OP_IMM:    optype = rv_decode_pkg::OPT_I;
            rv_decode_pkg::OP_STORE:  optype = rv_decode_pkg::OPT_S;
            rv_decode_pkg::OP_BRANCH: optype = rv_decode_pkg::OPT_B;
            rv_decode_pkg::OP_REG:    optype = rv_decode_pkg::OPT_R;
            rv_decode_pkg::OP_SYSTEM: optype = rv_decode_pkg::OPT_PRIV;
            default:                  optype = rv_decode_pkg::OPT_NONE;
        endcase
    end

    always_comb begin
        case (optype)
            rv_decode_pkg::OPT_I: imm = imm_i;
            rv_decode_pkg::OPT_S: imm = imm_s;
            rv_decode_pkg::OPT_B: imm = imm_b;
            rv_decode_pkg::OPT_U: imm = imm_u;
            rv_decode_pkg::OPT_J: imm = imm_j;
            default:              imm = 32'd0;  // r, priv and unknown.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        br_legal = (inst.b.opcode == rv_decode_pkg::OP_BRANCH);
        case (inst.b.funct3)
            3'b000:  cmp_fn = rv_decode_pkg::CMP_EQ;
            3'b001:  cmp_fn = rv_decode_pkg::CMP_NE;
            3'b100:  cmp_fn = rv_decode_pkg::CMP_LT;
            3'b101:  cmp_fn = rv_decode_pkg::CMP_GE;
            3'b110:  cmp_fn = rv_decode_pkg::CMP_LTU;
            3'b111:  cmp_fn = rv_decode_pkg::CMP_GEU;
            default: begin
                cmp_fn   = rv_decode_pkg::CMP_EQ;
                br_legal = 1'b0;              // 010 and 011 are reserved.
            end
        endcase
    end

    branch_compare u_cmp (
        .a_i      (rs1_val_i),
        .b_i      (rs2_val_i),
        .fn_i     (cmp_fn),
        .result_o (cmp_result)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rs1_idx_o  = inst.r.rs1;
    assign rs2_idx_o  = inst.r.rs2;
    assign csr_addr_o = inst.i.imm_11_0;

    always_comb begin
        decode_bus_o.pc       = held.pc;
        decode_bus_o.imm      = imm;
        decode_bus_o.rs1_val  = rs1_val_i;
        decode_bus_o.rs2_val  = rs2_val_i;
        decode_bus_o.rd       = inst.r.rd;
        decode_bus_o.br_taken = br_legal & cmp_result;
        decode_bus_o.csr_addr = inst.i.imm_11_0;
        decode_bus_o.csr_val  = csr_val_i;
        decode_bus_o.optype   = optype;
        decode_bus_o.opcode   = inst.r.opcode;
        decode_bus_o.funct3   = inst.r.funct3;
        decode_bus_o.funct7   = inst.r.funct7;
    end

endmodule

`default_nettype wire

/* source/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire [11:0] raddr_i,
    output logic [31:0] rdata_o,
    input  wire        we_i,
    input  wire [11:0] waddr_i,
    input  wire [31:0] wdata_i
);

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus <= 32'd0;
            mtvec   <= 32'd0;
            mepc    <= 32'd0;
            mcause  <= 32'd0;
        end else if (we_i) begin
            case (waddr_i)
                rv_decode_pkg::CSR_MSTATUS: mstatus <= wdata_i;
                rv_decode_pkg::CSR_MTVEC:   mtvec   <= wdata_i;
                rv_decode_pkg::CSR_MEPC:    mepc    <= wdata_i;
                rv_decode_pkg::CSR_MCAUSE:  mcause  <= wdata_i;
                default: ;                            // unimplemented, dropped.
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            rv_decode_pkg::CSR_MSTATUS: rdata_o = mstatus;
            rv_decode_pkg::CSR_MTVEC:   rdata_o = mtvec;
            rv_decode_pkg::CSR_MEPC:    rdata_o = mepc;
            rv_decode_pkg::CSR_MCAUSE:  rdata_o = mcause;
            default:                    rdata_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire [4:0]  raddr1_i,
    input  wire [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    input  wire        we_i,
    input  wire [4:0]  waddr_i,
    input  wire [31:0] wdata_i
);

    localparam int AW = $clog2(NUM_REGS);

    logic [31:0] regs [NUM_REGS];
    logic        wr_ok;
    logic        rd1_ok;
    logic        rd2_ok;

    // x0 is never written, so it keeps its reset value of zero.
    assign wr_ok  = we_i && (waddr_i != 5'd0) && (waddr_i < NUM_REGS);
    assign rd1_ok = (raddr1_i < NUM_REGS);
    assign rd2_ok = (raddr2_i < NUM_REGS);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_ok) begin
            regs[waddr_i[AW-1:0]] <= wdata_i;
        end
    end

    // no bypass, a same-cycle write shows up after the edge.
    assign rdata1_o = rd1_ok ? regs[raddr1_i[AW-1:0]] : 32'd0;
    assign rdata2_o = rd2_ok ? regs[raddr2_i[AW-1:0]] : 32'd0;

endmodule

`default_nettype wire

/* source/branch_compare.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_compare (
    input  wire [31:0]              a_i,
    input  wire [31:0]              b_i,
    input  wire rv_decode_pkg::cmp_fn_e fn_i,
    output logic                    result_o
);

    logic [32:0] diff;
    logic        eq;
    logic        lt_s;
    logic        lt_u;

    assign diff = {1'b0, a_i} - {1'b0, b_i};  // bit 32 is the borrow.
    assign eq   = (diff[31:0] == 32'd0);
    assign lt_u = diff[32];

    // differing signs settle it directly, otherwise no overflow is possible.
    assign lt_s = (a_i[31] ^ b_i[31]) ? a_i[31] : diff[31];

    always_comb begin
        case (fn_i)
            rv_decode_pkg::CMP_EQ:  result_o = eq;
            rv_decode_pkg::CMP_NE:  result_o = ~eq;
            rv_decode_pkg::CMP_LT:  result_o = lt_s;
            rv_decode_pkg::CMP_GE:  result_o = ~lt_s;
            rv_decode_pkg::CMP_LTU: result_o = lt_u;
            rv_decode_pkg::CMP_GEU: result_o = ~lt_u;
            default:                result_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes and csr addresses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_fmt_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // classification and bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        OPT_NONE = 3'd0,
        OPT_R,
        OPT_I,
        OPT_S,
        OPT_B,
        OPT_U,
        OPT_J,
        OPT_PRIV
    } optype_e;

    typedef enum logic [2:0] {
        CMP_EQ = 3'd0,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_fn_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [4:0]  rd;
        logic        br_taken;
        logic [11:0] csr_addr;
        logic [31:0] csr_val;
        optype_e     optype;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
    } decode_bus_t;  // 198 bits.

endpackage

`default_nettype wire
